/* tb.f */
hdl/mix_cfg_pkg.sv
hdl/mix_isa_pkg.sv
hdl/program_counter.sv
hdl/mix_ram.sv
hdl/sample_addr_gen.sv
hdl/mac_datapath.sv
hdl/mix_sequencer.sv
hdl/mix_engine.sv
verification/mix_tb.sv

/* run.sh */
#!/bin/sh
# Build the mixing engine testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module mix_tb -f tb.f -o mix_sim \
    && ./obj_dir/mix_sim | tee /dev/stderr | grep "^Result: PASSED$" > /dev/null \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

/* verification/mix_tb.sv */
`timescale 1ns/1ps

module mix_tb;

    logic ck;
    logic reset;
    logic start;
    mix_cfg_pkg::frame_t frame;
    mix_cfg_pkg::coef_wr_t coef_wr;
    mix_cfg_pkg::audio_wr_t audio_wr;
    mix_cfg_pkg::mix_out_t mix_out;
    logic busy;
    logic done;
    logic error;

    // Reference copies of both memories
    logic [31:0] prog_copy [mix_cfg_pkg::CODE_DEPTH];
    mix_cfg_pkg::sample_t audio_copy [mix_cfg_pkg::AUDIO_DEPTH];
    mix_cfg_pkg::acc_t model_acc;
    mix_cfg_pkg::mix_out_t exp_q [$];
    logic exp_err;
    logic [31:0] prog_q [$];
    string cur_test;
    int cycle_limit;
    int run_cycles;
    int unsigned seed;

    mix_engine uut (
        .ck(ck),
        .reset(reset),
        .start(start),
        .frame(frame),
        .coef_wr(coef_wr),
        .audio_wr(audio_wr),
        .out(mix_out),
        .busy(busy),
        .done(done),
        .error(error)
    );

    initial begin
        ck = 1'b0;
        forever #20 ck = ~ck;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_out(input string name, input mix_cfg_pkg::mix_out_t exp,
                             input mix_cfg_pkg::mix_out_t act);
        if (act !== exp) begin
            abort_run($sformatf(
                "Fail %s expected we=%0b chan=%0d data=%h actual we=%0b chan=%0d data=%h",
                name, exp.we, exp.chan, exp.data, act.we, act.chan, act.data));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s expected %0b actual %0b", name, exp, act));
        end
    endtask

    task automatic step_clk();
        @(posedge ck);
        #2;
    endtask

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($urandom_range(hi - lo));
    endfunction

    // Field order op, offset, chan, gain from the top bit
    function automatic logic [31:0] make_word(input logic [6:0] op, input logic [4:0] off,
                                              input logic [3:0] ch, input logic [15:0] g);
        return {op, off, ch, g};
    endfunction

    function automatic logic [31:0] rand_word(input logic [6:0] op);
        return make_word(op, 5'($urandom), 4'($urandom), 16'($urandom));
    endfunction

    function automatic logic [31:0] save_word(input logic [2:0] sh);
        return make_word(mix_isa_pkg::OP_SAVE, {2'($urandom), sh}, 4'($urandom), 16'($urandom));
    endfunction

    function automatic logic [6:0] rand_op();
        case ($urandom_range(3))
            0: return mix_isa_pkg::OP_MAC;
            1: return mix_isa_pkg::OP_MACZ;
            2: return mix_isa_pkg::OP_SAVE;
            default: return mix_isa_pkg::OP_NOP;
        endcase
    endfunction

    // Any code outside HALT, MAC, MACZ, SAVE and NOP
    function automatic logic [6:0] rand_bad_op();
        logic [6:0] code;
        code = 7'($urandom);
        while (code == 7'h00 || code == 7'h40 || code == 7'h41 || code == 7'h42
               || code == 7'h7F) begin
            code = 7'($urandom);
        end
        return code;
    endfunction

    // Sequential execution of the loaded program
    task automatic model_run(input mix_cfg_pkg::frame_t fr);
        mix_isa_pkg::instr_t w;
        mix_cfg_pkg::mix_out_t wr;
        logic signed [31:0] prod;
        mix_cfg_pkg::acc_t shifted;
        int pc;
        int idx;
        int steps;
        bit stop;
        pc = 0;
        steps = 0;
        stop = 1'b0;
        exp_err = 1'b0;
        while (!stop) begin
            w = prog_copy[pc];
            idx = int'(w.chan) * mix_cfg_pkg::FRAMES
                + (int'(fr) + int'(w.offset)) % mix_cfg_pkg::FRAMES;
            prod = 32'(w.gain) * 32'(audio_copy[idx]);
            case (w.op)
                mix_isa_pkg::OP_MAC: model_acc = model_acc + 40'(prod);
                mix_isa_pkg::OP_MACZ: model_acc = 40'(prod);
                mix_isa_pkg::OP_SAVE: begin
                    shifted = model_acc >>> (4 * int'(w.offset[2:0]));
                    wr.we = 1'b1;
                    wr.chan = w.chan;
                    wr.data = (w.offset[2:0] == 3'd7) ? 16'h0000 : shifted[15:0];
                    exp_q.push_back(wr);
                end
                mix_isa_pkg::OP_NOP: begin
                end
                mix_isa_pkg::OP_HALT: stop = 1'b1;
                default: begin
                    stop = 1'b1;
                    exp_err = 1'b1;
                end
            endcase
            pc = (pc + 1) % mix_cfg_pkg::CODE_DEPTH;
            steps++;
            if (!stop && steps >= mix_cfg_pkg::CODE_DEPTH) begin
                abort_run("Reference model ran a program without a halting word");
            end
        end
    endtask

    task automatic load_audio();
        for (int a = 0; a < mix_cfg_pkg::AUDIO_DEPTH; a++) begin
            audio_wr.we = 1'b1;
            audio_wr.addr = mix_cfg_pkg::audio_addr_t'(a);
            audio_wr.data = mix_cfg_pkg::sample_t'($urandom);
            audio_copy[a] = audio_wr.data;
            step_clk();
        end
        audio_wr.we = 1'b0;
    endtask

    // Load prog_q at address zero, run it and wait for done
    task automatic run_prog(input string name, input mix_cfg_pkg::frame_t fr, input bit poke);
        int len;
        int n;
        len = prog_q.size();
        cur_test = name;
        for (int i = 0; i < len; i++) begin
            coef_wr.we = 1'b1;
            coef_wr.addr = mix_cfg_pkg::code_addr_t'(i);
            coef_wr.data = prog_q[i];
            prog_copy[i] = prog_q[i];
            step_clk();
        end
        coef_wr.we = 1'b0;
        model_run(fr);
        cycle_limit += (len + 20) * 2;
        frame = fr;
        start = 1'b1;
        step_clk();
        start = 1'b0;
        frame = 5'($urandom);
        check_flag({name, " busy"}, 1'b1, busy);
        n = 0;
        while (!done) begin
            // A second start while busy must be ignored
            if (poke && n == 3) begin
                start = 1'b1;
                frame = ~fr;
            end else begin
                start = 1'b0;
            end
            step_clk();
            n++;
            run_cycles++;
            if (run_cycles > cycle_limit) begin
                abort_run($sformatf("Timeout in %s, done never rose", name));
            end
        end
        start = 1'b0;
        check_flag({name, " error"}, exp_err, error);
        if (exp_q.size() != 0) begin
            abort_run($sformatf("%s ended with %0d output writes missing", name, exp_q.size()));
        end
    endtask

    // Output and status monitor on the falling edge
    always @(negedge ck) begin
        if (reset) begin
            if (done && busy) begin
                abort_run($sformatf("%s had done and busy high together", cur_test));
            end
            if (mix_out.we) begin
                if (exp_q.size() == 0) begin
                    abort_run($sformatf("%s gave an output write that was not expected",
                                        cur_test));
                end else begin
                    check_out(cur_test, exp_q.pop_front(), mix_out);
                end
            end
        end
    end

    initial begin
        int n;
        int pos;
        mix_cfg_pkg::frame_t fr;
        logic [4:0] off;
        seed = $urandom(85);
        reset = 1'b0;
        start = 1'b0;
        frame = '0;
        coef_wr = '0;
        audio_wr = '0;
        model_acc = '0;
        cycle_limit = 0;
        run_cycles = 0;
        cur_test = "reset";
        repeat (8) @(posedge ck);
        #2;
        reset = 1'b1;
        check_flag("reset busy", 1'b0, busy);
        check_flag("reset done", 1'b0, done);
        check_flag("reset error", 1'b0, error);
        check_flag("reset out.we", 1'b0, mix_out.we);
        load_audio();

        // MAC and MACZ chains closed by one SAVE
        for (int r = 0; r < 6; r++) begin
            prog_q.delete();
            // First chain adds onto the accumulator left by reset
            prog_q.push_back(rand_word((r == 0) ? mix_isa_pkg::OP_MAC : mix_isa_pkg::OP_MACZ));
            n = rand_range(2, 9);
            repeat (n) begin
                prog_q.push_back(rand_word(($urandom_range(3) == 0) ? mix_isa_pkg::OP_MACZ
                                                                    : mix_isa_pkg::OP_MAC));
            end
            prog_q.push_back(save_word(3'($urandom_range(6))));
            prog_q.push_back(make_word(mix_isa_pkg::OP_HALT, '0, '0, '0));
            run_prog($sformatf("mac_seq_%0d", r), 5'($urandom), 1'b0);
        end

        // Frame plus offset past the last frame
        for (int r = 0; r < 4; r++) begin
            prog_q.delete();
            fr = 5'(16 + rand_range(0, 15));
            off = 5'(32 - int'(fr) + rand_range(0, int'(fr) - 1));
            prog_q.push_back(make_word(mix_isa_pkg::OP_MACZ, off, 4'($urandom), 16'($urandom)));
            prog_q.push_back(save_word(3'($urandom_range(6))));
            off = 5'(32 - int'(fr) + rand_range(0, int'(fr) - 1));
            prog_q.push_back(make_word(mix_isa_pkg::OP_MAC, off, 4'($urandom), 16'($urandom)));
            prog_q.push_back(save_word(3'($urandom_range(6))));
            prog_q.push_back(make_word(mix_isa_pkg::OP_HALT, '0, '0, '0));
            run_prog($sformatf("frame_wrap_%0d", r), fr, 1'b0);
        end

        // Zero window, NOP gaps and back to back SAVEs
        prog_q.delete();
        prog_q.push_back(rand_word(mix_isa_pkg::OP_MACZ));
        prog_q.push_back(save_word(3'd7));
        prog_q.push_back(rand_word(mix_isa_pkg::OP_MAC));
        prog_q.push_back(rand_word(mix_isa_pkg::OP_NOP));
        prog_q.push_back(rand_word(mix_isa_pkg::OP_NOP));
        prog_q.push_back(save_word(3'($urandom_range(6))));
        prog_q.push_back(save_word(3'($urandom_range(6))));
        prog_q.push_back(rand_word(mix_isa_pkg::OP_NOP));
        prog_q.push_back(rand_word(mix_isa_pkg::OP_MAC));
        prog_q.push_back(save_word(3'($urandom_range(6))));
        prog_q.push_back(make_word(mix_isa_pkg::OP_HALT, '0, '0, '0));
        run_prog("window_cases", 5'($urandom), 1'b0);
        // Accumulator carries over into a program without MACZ
        prog_q.delete();
        prog_q.push_back(rand_word(mix_isa_pkg::OP_MAC));
        prog_q.push_back(save_word(3'($urandom_range(6))));
        prog_q.push_back(make_word(mix_isa_pkg::OP_HALT, '0, '0, '0));
        run_prog("acc_carry", 5'($urandom), 1'b0);

        // Unknown opcode stops the run with error
        for (int r = 0; r < 4; r++) begin
            prog_q.delete();
            prog_q.push_back(rand_word(mix_isa_pkg::OP_MACZ));
            pos = rand_range(1, 8);
            repeat (pos) begin
                prog_q.push_back(rand_word(rand_op()));
            end
            prog_q.push_back(rand_word(rand_bad_op()));
            n = rand_range(1, 4);
            repeat (n) begin
                prog_q.push_back(save_word(3'($urandom_range(6))));
            end
            prog_q.push_back(make_word(mix_isa_pkg::OP_HALT, '0, '0, '0));
            run_prog($sformatf("bad_opcode_%0d", r), 5'($urandom), 1'b0);
        end

        // HALT first and then a new program with a start pulse while busy
        prog_q.delete();
        prog_q.push_back(make_word(mix_isa_pkg::OP_HALT, '0, '0, '0));
        run_prog("halt_first", 5'($urandom), 1'b0);
        prog_q.delete();
        prog_q.push_back(rand_word(mix_isa_pkg::OP_MACZ));
        prog_q.push_back(rand_word(mix_isa_pkg::OP_MAC));
        prog_q.push_back(save_word(3'($urandom_range(6))));
        prog_q.push_back(rand_word(mix_isa_pkg::OP_MAC));
        prog_q.push_back(save_word(3'($urandom_range(6))));
        prog_q.push_back(make_word(mix_isa_pkg::OP_HALT, '0, '0, '0));
        run_prog("restart", 5'($urandom), 1'b1);

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* hdl/mix_engine.sv */
`timescale 1ns/1ps

module mix_engine (
    input logic ck,
    input logic reset,
    input logic start,
    input mix_cfg_pkg::frame_t frame,
    input mix_cfg_pkg::coef_wr_t coef_wr,
    input mix_cfg_pkg::audio_wr_t audio_wr,
    output mix_cfg_pkg::mix_out_t out,
    output logic busy,
    output logic done,
    output logic error
);

    logic pc_clear;
    logic pc_step;
    mix_cfg_pkg::code_addr_t pc;
    mix_isa_pkg::instr_t code_word;
    mix_cfg_pkg::chan_t rd_chan;
    mix_cfg_pkg::frame_t rd_offset;
    mix_cfg_pkg::frame_t run_frame;
    mix_cfg_pkg::audio_addr_t audio_raddr;
    mix_cfg_pkg::sample_t sample;
    mix_cfg_pkg::sample_t gain;
    mix_isa_pkg::mac_ctrl_t ctrl;

    program_counter u_pc (
        .ck(ck),
        .reset(reset),
        .clear(pc_clear),
        .step(pc_step),
        .addr(pc)
    );

    // Program store
    mix_ram #(.WIDTH(mix_cfg_pkg::WORD_W), .DEPTH(mix_cfg_pkg::CODE_DEPTH)) coef_ram (
        .ck(ck),
        .we(coef_wr.we),
        .waddr(coef_wr.addr),
        .wdata(coef_wr.data),
        .raddr(pc),
        .rdata(code_word)
    );

    mix_sequencer u_seq (
        .ck(ck),
        .reset(reset),
        .start(start),
        .frame(frame),
        .instr(code_word),
        .pc(pc),
        .pc_clear(pc_clear),
        .pc_step(pc_step),
        .rd_chan(rd_chan),
        .rd_offset(rd_offset),
        .run_frame(run_frame),
        .gain(gain),
        .ctrl(ctrl),
        .busy(busy),
        .done(done),
        .error(error)
    );

    sample_addr_gen u_addr (
        .ck(ck),
        .chan(rd_chan),
        .frame(run_frame),
        .offset(rd_offset),
        .addr(audio_raddr)
    );

    // Sample store, channel major
    mix_ram #(.WIDTH(mix_cfg_pkg::SAMPLE_W), .DEPTH(mix_cfg_pkg::AUDIO_DEPTH)) audio_ram (
        .ck(ck),
        .we(audio_wr.we),
        .waddr(audio_wr.addr),
        .wdata(audio_wr.data),
        .raddr(audio_raddr),
        .rdata(sample)
    );

    mac_datapath u_mac (
        .ck(ck),
        .reset(reset),
        .sample(sample),
        .gain(gain),
        .ctrl(ctrl),
        .out(out)
    );

endmodule

/* hdl/mix_sequencer.sv */
`timescale 1ns/1ps

module mix_sequencer (
    input logic ck,
    input logic reset,
    input logic start,
    input mix_cfg_pkg::frame_t frame,
    input mix_isa_pkg::instr_t instr,
    input mix_cfg_pkg::code_addr_t pc,
    output logic pc_clear,
    output logic pc_step,
    output mix_cfg_pkg::chan_t rd_chan,
    output mix_cfg_pkg::frame_t rd_offset,
    output mix_cfg_pkg::frame_t run_frame,
    output mix_cfg_pkg::sample_t gain,
    output mix_isa_pkg::mac_ctrl_t ctrl,
    output logic busy,
    output logic done,
    output logic error
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FILL,
        S_RUN,
        S_DRAIN
    } state_t;

    state_t state;
    logic accept;
    logic stop;
    logic bad_op;
    logic err_hold;
    logic [2:0] drain_cnt;
    mix_isa_pkg::mac_ctrl_t dec;
    mix_isa_pkg::mac_ctrl_t ctrl_d;
    mix_isa_pkg::mac_ctrl_t ctrl_p;
    mix_cfg_pkg::sample_t gain_d;
    mix_cfg_pkg::sample_t gain_p;

    assign accept = (state == S_IDLE) && start;
    assign pc_clear = accept;
    assign pc_step = (state == S_FILL) || (state == S_RUN);

    // Decode of the word on the program RAM output
    always_comb begin
        dec = '0;
        stop = 1'b0;
        bad_op = 1'b0;
        dec.chan = instr.chan;
        case (instr.op)
            mix_isa_pkg::OP_MAC: begin
                dec.mac_en = 1'b1;
            end
            mix_isa_pkg::OP_MACZ: begin
                dec.mac_en = 1'b1;
                dec.acc_clear = 1'b1;
            end
            mix_isa_pkg::OP_SAVE: begin
                dec.save = 1'b1;
                dec.shift = instr.offset[mix_isa_pkg::SHIFT_W-1:0];
            end
            mix_isa_pkg::OP_NOP: begin
            end
            mix_isa_pkg::OP_HALT: begin
                stop = 1'b1;
            end
            default: begin
                stop = 1'b1;
                bad_op = 1'b1;
            end
        endcase
    end

    always_ff @(posedge ck) begin
        if (!reset) begin
            state <= S_IDLE;
            busy <= 1'b0;
            done <= 1'b0;
            error <= 1'b0;
            err_hold <= 1'b0;
            drain_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_FILL;
                        busy <= 1'b1;
                        done <= 1'b0;
                        error <= 1'b0;
                        err_hold <= 1'b0;
                    end
                end
                S_FILL: begin
                    state <= S_RUN;
                end
                S_RUN: begin
                    if (stop) begin
                        state <= S_DRAIN;
                        err_hold <= bad_op;
                        drain_cnt <= 3'(mix_isa_pkg::DRAIN_CYCLES);
                    end
                end
                S_DRAIN: begin
                    // Wait for older instructions to reach the output
                    if (drain_cnt == '0) begin
                        state <= S_IDLE;
                        busy <= 1'b0;
                        done <= 1'b1;
                        error <= err_hold;
                    end else begin
                        drain_cnt <= drain_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Control pipe, words outside RUN become bubbles
    always_ff @(posedge ck) begin
        if (!reset) begin
            ctrl_d <= '0;
            ctrl_p <= '0;
            ctrl <= '0;
        end else begin
            ctrl_d <= (state == S_RUN) ? dec : '0;
            ctrl_p <= ctrl_d;
            ctrl <= ctrl_p;
        end
    end

    // Operand fields, gain lines up with the sample read
    always_ff @(posedge ck) begin
        rd_chan <= instr.chan;
        rd_offset <= instr.offset;
        gain_d <= instr.gain;
        gain_p <= gain_d;
        gain <= gain_p;
        if (accept) begin
            run_frame <= frame;
        end
    end

    assert property (@(posedge ck) disable iff (!reset) !(done && busy))
        else $error("done and busy high together");

    assert property (@(posedge ck) disable iff (!reset)
        (start && busy) |=> $stable(run_frame))
        else $error("start taken while busy");

    // First fetch must come from word zero
    assert property (@(posedge ck) disable iff (!reset) (state == S_FILL) |-> (pc == '0))
        else $error("first fetch not at address zero");

endmodule

/* hdl/mac_datapath.sv */
`timescale 1ns/1ps

module mac_datapath (
    input logic ck,
    input logic reset,
    input mix_cfg_pkg::sample_t sample,
    input mix_cfg_pkg::sample_t gain,
    input mix_isa_pkg::mac_ctrl_t ctrl,
    output mix_cfg_pkg::mix_out_t out
);

    logic signed [mix_cfg_pkg::PROD_W-1:0] prod_q;
    mix_isa_pkg::mac_ctrl_t ctrl_q;
    mix_cfg_pkg::acc_t acc;
    mix_cfg_pkg::acc_t prod_ext;
    mix_cfg_pkg::sample_t window;
    mix_cfg_pkg::mix_out_t win_q;

    // Multiply stage
    always_ff @(posedge ck) begin
        prod_q <= gain * sample;
    end

    always_ff @(posedge ck) begin
        if (!reset) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= ctrl;
        end
    end

    assign prod_ext = {{(mix_cfg_pkg::ACC_W - mix_cfg_pkg::PROD_W){prod_q[mix_cfg_pkg::PROD_W-1]}},
                       prod_q};

    // Accumulator, wraps at full width
    always_ff @(posedge ck) begin
        if (!reset) begin
            acc <= '0;
        end else if (ctrl_q.acc_clear) begin
            acc <= ctrl_q.mac_en ? prod_ext : '0;
        end else if (ctrl_q.mac_en) begin
            acc <= acc + prod_ext;
        end
    end

    // 16-bit window in steps of four bits, top code reads zero
    always_comb begin
        if (ctrl_q.shift == '1) begin
            window = '0;
        end else begin
            window = acc[4 * ctrl_q.shift +: mix_cfg_pkg::SAMPLE_W];
        end
    end

    // Window register, then the output register
    always_ff @(posedge ck) begin
        if (!reset) begin
            win_q <= '0;
            out <= '0;
        end else begin
            win_q.we <= ctrl_q.save;
            win_q.chan <= ctrl_q.chan;
            win_q.data <= window;
            out <= win_q;
        end
    end

    // A write with the zero window code carries no data
    assert property (@(posedge ck) disable iff (!reset)
        out.we |-> (out.data == '0) || ($past(ctrl_q.shift, 2) != 3'd7))
        else $error("nonzero output for shift 7");

endmodule

/* hdl/sample_addr_gen.sv */
`timescale 1ns/1ps

module sample_addr_gen (
    input logic ck,
    input mix_cfg_pkg::chan_t chan,
    input mix_cfg_pkg::frame_t frame,
    input mix_cfg_pkg::frame_t offset,
    output mix_cfg_pkg::audio_addr_t addr
);

    mix_cfg_pkg::frame_t rel_frame;

    // Frame relative to the run frame, wrapped around the channel
    assign rel_frame = mix_cfg_pkg::frame_t'((frame + offset) % mix_cfg_pkg::FRAMES);

    // Channel selects the block of frames
    always_ff @(posedge ck) begin
        addr <= {chan, rel_frame};
    end

endmodule

/* hdl/mix_ram.sv */
`timescale 1ns/1ps

module mix_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 256
) (
    input logic ck,
    input logic we,
    input logic [$clog2(DEPTH)-1:0] waddr,
    input logic [WIDTH-1:0] wdata,
    input logic [$clog2(DEPTH)-1:0] raddr,
    output logic [WIDTH-1:0] rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Read sees the old word on a same-address write
    always_ff @(posedge ck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

/* hdl/program_counter.sv */
`timescale 1ns/1ps

module program_counter (
    input logic ck,
    input logic reset,
    input logic clear,
    input logic step,
    output mix_cfg_pkg::code_addr_t addr
);

    // Fetch address, wraps from the last word back to zero
    always_ff @(posedge ck) begin
        if (!reset) begin
            addr <= '0;
        end else if (clear) begin
            addr <= '0;
        end else if (step) begin
            addr <= addr + 1'b1;
        end
    end

    // Sequencer never asks for both at once
    assert property (@(posedge ck) disable iff (!reset) !(clear && step))
        else $error("program counter got clear and step together");

endmodule

/* hdl/mix_isa_pkg.sv */
package mix_isa_pkg;

    localparam int OP_W = 7;
    localparam int SHIFT_W = 3;

    // Cycles spent in DRAIN after the halting word leaves decode
    localparam int DRAIN_CYCLES = 4;

    typedef enum logic [OP_W-1:0] {
        OP_HALT = 7'h00,
        OP_MAC = 7'h40,
        OP_MACZ = 7'h41,
        OP_SAVE = 7'h42,
        OP_NOP = 7'h7F
    } op_t;

    // Program word, top bit first
    typedef struct packed {
        op_t op;
        mix_cfg_pkg::frame_t offset;
        mix_cfg_pkg::chan_t chan;
        mix_cfg_pkg::sample_t gain;
    } instr_t;

    // Control carried down the pipe with each instruction
    typedef struct packed {
        // Add this product
        logic mac_en;
        // Clear the accumulator first
        logic acc_clear;
        // Write the window out
        logic save;
        logic [SHIFT_W-1:0] shift;
        mix_cfg_pkg::chan_t chan;
    } mac_ctrl_t;

endpackage

/* hdl/mix_cfg_pkg.sv */
package mix_cfg_pkg;

    // Channel and frame geometry
    localparam int CHANNELS = 16;
    localparam int CHAN_W = $clog2(CHANNELS);
    localparam int FRAMES = 32;
    localparam int FRAME_W = $clog2(FRAMES);

    // Program and audio memories
    localparam int CODE_DEPTH = 256;
    localparam int CODE_W = $clog2(CODE_DEPTH);
    localparam int AUDIO_DEPTH = CHANNELS * FRAMES;
    localparam int AUDIO_W = $clog2(AUDIO_DEPTH);
    localparam int WORD_W = 32;

    // Arithmetic widths
    localparam int SAMPLE_W = 16;
    localparam int PROD_W = 2 * SAMPLE_W;
    localparam int ACC_W = 40;

    typedef logic [CHAN_W-1:0] chan_t;
    typedef logic [FRAME_W-1:0] frame_t;
    typedef logic [CODE_W-1:0] code_addr_t;
    typedef logic [AUDIO_W-1:0] audio_addr_t;
    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    // Program load port
    typedef struct packed {
        logic we;
        code_addr_t addr;
        logic [WORD_W-1:0] data;
    } coef_wr_t;

    // Audio load port
    typedef struct packed {
        logic we;
        audio_addr_t addr;
        sample_t data;
    } audio_wr_t;

    // One output channel write
    typedef struct packed {
        logic we;
        chan_t chan;
        sample_t data;
    } mix_out_t;

endpackage
